//--- hdl/m92_input_pkg.sv
/*
 * M92 player input package
 * Widths, joystick bit positions, DIP switch constants and the
 * structs that carry controller, keyboard and download signals
 * through the player-input section.
 */

`default_nettype none

package m92_input_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int PLAYERS           = 4;
    localparam int PLAYER_BITS       = 10;
    localparam int JOY_BITS          = 20;
    localparam int KBD_BITS          = 16;
    localparam int LLAPI_BUTTON_BITS = 32;
    localparam int LLAPI_TYPE_BITS   = 8;
    localparam int DIP_BYTE_BITS     = 8;
    localparam int IOCTL_INDEX_BITS  = 8;
    localparam int IOCTL_ADDR_BITS   = 25;
    localparam int IOCTL_DATA_BITS   = 8;

    // Core joystick layout above the player word
    localparam int JOY_BIT_START      = 10;
    localparam int JOY_BIT_COIN       = 11;
    localparam int JOY_BIT_START2_ALT = 12;
    localparam int JOY_BIT_PAUSE      = 13;

    // Wired controller buttons forming the menu combination
    localparam int LLAPI_BTN_DOWN  = 26;
    localparam int LLAPI_BTN_START = 5;
    localparam int LLAPI_BTN_FIRST = 0;

    // DIP bank, written through download index 254
    localparam logic [IOCTL_INDEX_BITS-1:0] DIP_IOCTL_INDEX = 8'd254;
    localparam int DIP_BYTES      = 8;
    localparam int DIP_BYTES_USED = 3;
    localparam int DIP_ADDR_BITS  = $clog2(DIP_BYTES);

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [JOY_BITS-1:0]          joy_word_t;
    typedef logic [PLAYER_BITS-1:0]       player_input_t;
    typedef logic [KBD_BITS-1:0]          kbd_word_t;
    typedef logic [LLAPI_BUTTON_BITS-1:0] llapi_buttons_t;
    typedef logic [LLAPI_TYPE_BITS-1:0]   llapi_type_t;
    typedef logic [DIP_BYTE_BITS-1:0]     dip_byte_t;

    // One decoded wired controller port
    typedef struct packed {
        llapi_buttons_t buttons;
        llapi_type_t    type_id;
        logic           en;
    } llapi_port_t;

    // Four joystick words, index 0 is player 1
    typedef struct packed {
        joy_word_t [PLAYERS-1:0] joy;
    } usb_joys_t;

    typedef struct packed {
        kbd_word_t [PLAYERS-1:0] p;
        logic [PLAYERS-1:0]      start;
        logic [PLAYERS-1:0]      coin;
        logic                    pause;
    } kbd_inputs_t;

    // Host download write strobe with its address and data
    typedef struct packed {
        logic                        wr;
        logic [IOCTL_INDEX_BITS-1:0] index;
        logic [IOCTL_ADDR_BITS-1:0]  addr;
        logic [IOCTL_DATA_BITS-1:0]  dout;
    } ioctl_wr_t;

endpackage

`default_nettype wire

//--- hdl/llapi_port_decode.sv
/*
 * Wired controller port decoder
 * Decides whether a controller sits on the port, remaps its
 * buttons into the core joystick layout and flags the
 * down+start+first-button menu combination.
 */

`timescale 1ns/1ns
`default_nettype none

module llapi_port_decode (
    input  wire                     clk_sys,
    input  wire                     reset,
    input  m92_input_pkg::llapi_port_t port,
    output logic                    use_port,
    output m92_input_pkg::joy_word_t joy_mapped,
    output logic                    osd_combo
);

    import m92_input_pkg::*;

    logic pressed;
    logic type_known;

    // Sticky flag, set by any button and held until reset
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pressed <= 1'b0;
        end else if (|port.buttons) begin
            pressed <= 1'b1;
        end
    end

    // Id 0 covers both an empty port and an Atari pad, 255 is
    // treated the same way
    assign type_known = (|port.type_id) && !(&port.type_id);
    assign use_port   = port.en && (type_known || pressed);

    ////////////////////////////////////////////////////////////
    // Button remap
    ////////////////////////////////////////////////////////////

    always_comb begin
        joy_mapped = '0;
        // D-pad
        joy_mapped[3:0] = port.buttons[27:24];
        // A, B, C
        joy_mapped[4] = port.buttons[0];
        joy_mapped[5] = port.buttons[1];
        joy_mapped[6] = port.buttons[2];
        // D, E, F
        joy_mapped[7] = port.buttons[3];
        joy_mapped[8] = port.buttons[6];
        joy_mapped[9] = port.buttons[7];
        joy_mapped[JOY_BIT_START] = port.buttons[5];
        joy_mapped[JOY_BIT_COIN]  = port.buttons[4];
    end

    // Menu combination
    assign osd_combo = port.buttons[LLAPI_BTN_DOWN]
                     & port.buttons[LLAPI_BTN_START]
                     & port.buttons[LLAPI_BTN_FIRST];

endmodule

`default_nettype wire

//--- hdl/player_slot_assign.sv
/*
 * Player slot assignment
 * Present wired controllers take the first player slots and
 * the USB joysticks move over to the slots that remain.
 */

`timescale 1ns/1ns
`default_nettype none

module player_slot_assign (
    input  wire                      use_a,
    input  wire                      use_b,
    input  m92_input_pkg::joy_word_t joy_a,
    input  m92_input_pkg::joy_word_t joy_b,
    input  m92_input_pkg::usb_joys_t usb,
    output m92_input_pkg::usb_joys_t slots
);

    import m92_input_pkg::*;

    always_comb begin
        if (use_a && use_b) begin
            slots.joy[0] = joy_a;
            slots.joy[1] = joy_b;
            slots.joy[2] = usb.joy[0];
            slots.joy[3] = usb.joy[1];
        end else if (use_a ^ use_b) begin
            // USB 0 fills whichever of the first two slots is free
            slots.joy[0] = use_a ? joy_a : usb.joy[0];
            slots.joy[1] = use_b ? joy_b : usb.joy[0];
            slots.joy[2] = usb.joy[1];
            slots.joy[3] = usb.joy[2];
        end else begin
            // No wired controllers, USB joysticks in order
            for (int i = 0; i < PLAYERS; i++) begin
                slots.joy[i] = usb.joy[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/arcade_input_merge.sv
/*
 * Arcade input merge
 * ORs keyboard and joystick sources per player and forms the
 * cabinet start, coin and pause signals.
 */

`timescale 1ns/1ns
`default_nettype none

module arcade_input_merge (
    input  m92_input_pkg::usb_joys_t     slots,
    input  m92_input_pkg::kbd_inputs_t   kbd,
    output m92_input_pkg::player_input_t p1,
    output m92_input_pkg::player_input_t p2,
    output m92_input_pkg::player_input_t p3,
    output m92_input_pkg::player_input_t p4,
    output logic [m92_input_pkg::PLAYERS-1:0] start_buttons,
    output logic [m92_input_pkg::PLAYERS-1:0] coin,
    output logic                         pause
);

    import m92_input_pkg::*;

    player_input_t [PLAYERS-1:0] merged;
    joy_word_t                   combined;

    ////////////////////////////////////////////////////////////
    // Player words
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < PLAYERS; i++) begin
            merged[i] = kbd.p[i][PLAYER_BITS-1:0] | slots.joy[i][PLAYER_BITS-1:0];
        end
    end

    assign p1 = merged[0];
    assign p2 = merged[1];
    assign p3 = merged[2];
    assign p4 = merged[3];

    ////////////////////////////////////////////////////////////
    // Cabinet buttons
    ////////////////////////////////////////////////////////////

    // Any joystick may drive the shared coin, pause and alt start
    always_comb begin
        combined = '0;
        for (int i = 0; i < PLAYERS; i++) begin
            combined = combined | slots.joy[i];
        end
    end

    always_comb begin
        for (int i = 0; i < PLAYERS; i++) begin
            start_buttons[i] = slots.joy[i][JOY_BIT_START] | kbd.start[i];
        end
        start_buttons[1] = start_buttons[1] | combined[JOY_BIT_START2_ALT];
    end

    // Single coin slot fed by every source
    always_comb begin
        coin    = '0;
        coin[0] = combined[JOY_BIT_COIN] | (|kbd.coin);
    end

    assign pause = combined[JOY_BIT_PAUSE] | kbd.pause;

endmodule

`default_nettype wire

//--- hdl/dip_switch_bank.sv
/*
 * DIP switch bank
 * Captures DIP switch bytes from the host download stream and
 * presents the ones the game reads. Bytes are active low.
 */

`timescale 1ns/1ns
`default_nettype none

module dip_switch_bank (
    input  wire                      clk_sys,
    input  wire                      reset,
    input  m92_input_pkg::ioctl_wr_t ioctl,
    output m92_input_pkg::dip_byte_t [m92_input_pkg::DIP_BYTES_USED-1:0] dip_sw
);

    import m92_input_pkg::*;

    dip_byte_t [DIP_BYTES-1:0] bank;
    logic                      dip_write;

    // Only the first DIP_BYTES addresses of the DIP index hit the bank
    assign dip_write = ioctl.wr
                    && (ioctl.index == DIP_IOCTL_INDEX)
                    && (ioctl.addr[IOCTL_ADDR_BITS-1:DIP_ADDR_BITS] == '0);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            // All switches off
            bank <= '1;
        end else if (dip_write) begin
            bank[ioctl.addr[DIP_ADDR_BITS-1:0]] <= ioctl.dout;
        end
    end

    assign dip_sw = bank[DIP_BYTES_USED-1:0];

endmodule

`default_nettype wire

//--- hdl/m92_input_top.sv
/*
 * M92 player input top level
 * Decodes the two wired controller ports, assigns player slots,
 * merges keyboard input and captures the DIP switches. Also
 * raises the menu button from either wired port.
 */

`timescale 1ns/1ns
`default_nettype none

module m92_input_top (
    input  wire                          clk_sys,
    input  wire                          reset,
    input  m92_input_pkg::llapi_port_t   port_a,
    input  m92_input_pkg::llapi_port_t   port_b,
    input  m92_input_pkg::usb_joys_t     usb,
    input  m92_input_pkg::kbd_inputs_t   kbd,
    input  m92_input_pkg::ioctl_wr_t     ioctl,
    output m92_input_pkg::player_input_t p1,
    output m92_input_pkg::player_input_t p2,
    output m92_input_pkg::player_input_t p3,
    output m92_input_pkg::player_input_t p4,
    output logic [m92_input_pkg::PLAYERS-1:0] start_buttons,
    output logic [m92_input_pkg::PLAYERS-1:0] coin,
    output logic                         pause,
    output logic                         osd_button,
    output m92_input_pkg::dip_byte_t [m92_input_pkg::DIP_BYTES_USED-1:0] dip_sw
);

    import m92_input_pkg::*;

    logic      use_a;
    logic      use_b;
    joy_word_t joy_a;
    joy_word_t joy_b;
    logic      combo_a;
    logic      combo_b;
    usb_joys_t slots;

    ////////////////////////////////////////////////////////////
    // Wired controller ports
    ////////////////////////////////////////////////////////////

    llapi_port_decode decode_a (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .port       (port_a),
        .use_port   (use_a),
        .joy_mapped (joy_a),
        .osd_combo  (combo_a)
    );

    llapi_port_decode decode_b (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .port       (port_b),
        .use_port   (use_b),
        .joy_mapped (joy_b),
        .osd_combo  (combo_b)
    );

    assign osd_button = combo_a | combo_b;

    ////////////////////////////////////////////////////////////
    // Slots, merge and DIP bank
    ////////////////////////////////////////////////////////////

    player_slot_assign player_slot_assign_i (
        .use_a (use_a),
        .use_b (use_b),
        .joy_a (joy_a),
        .joy_b (joy_b),
        .usb   (usb),
        .slots (slots)
    );

    arcade_input_merge arcade_input_merge_i (
        .slots         (slots),
        .kbd           (kbd),
        .p1            (p1),
        .p2            (p2),
        .p3            (p3),
        .p4            (p4),
        .start_buttons (start_buttons),
        .coin          (coin),
        .pause         (pause)
    );

    dip_switch_bank dip_switch_bank_i (
        .clk_sys (clk_sys),
        .reset   (reset),
        .ioctl   (ioctl),
        .dip_sw  (dip_sw)
    );

endmodule

`default_nettype wire

//--- verif/m92_input_assertions.sv
/*
 * M92 input assertions
 * Concurrent checks on the pressed flags, the menu button and
 * the DIP switch bank, bound into the input top level.
 */

`timescale 1ns/1ns
`default_nettype none

module m92_input_assertions (
    input wire                        clk_sys,
    input wire                        reset,
    input wire                        pressed_a,
    input wire                        pressed_b,
    input m92_input_pkg::llapi_port_t port_a,
    input m92_input_pkg::llapi_port_t port_b,
    input wire                        osd_button,
    input m92_input_pkg::ioctl_wr_t   ioctl,
    input m92_input_pkg::dip_byte_t [m92_input_pkg::DIP_BYTES_USED-1:0] dip_sw
);

    import m92_input_pkg::*;

    logic menu_a;
    logic menu_b;
    logic dip_write;

    // Down, start and first button held together on one wired port
    assign menu_a = port_a.buttons[LLAPI_BTN_DOWN] && port_a.buttons[LLAPI_BTN_START]
                 && port_a.buttons[LLAPI_BTN_FIRST];
    assign menu_b = port_b.buttons[LLAPI_BTN_DOWN] && port_b.buttons[LLAPI_BTN_START]
                 && port_b.buttons[LLAPI_BTN_FIRST];

    // Qualifying download strobe for the DIP bank
    assign dip_write = ioctl.wr && (ioctl.index == DIP_IOCTL_INDEX)
                    && (ioctl.addr[IOCTL_ADDR_BITS-1:3] == '0);

    // Reset clears both sticky flags
    assert property (@(posedge clk_sys) reset |=> (!pressed_a && !pressed_b))
        else $error("pressed flag still set after reset");

    assert property (@(posedge clk_sys) disable iff (reset)
        osd_button |-> (menu_a || menu_b))
        else $error("menu button without a port combination");

    // DIP bytes move only after a write or a reset
    assert property (@(posedge clk_sys) disable iff (reset)
        !$stable(dip_sw) |-> ($past(dip_write) || $past(reset)))
        else $error("DIP switches changed without a qualifying write");

endmodule

bind m92_input_top m92_input_assertions m92_input_assertions_i (
    .clk_sys    (clk_sys),
    .reset      (reset),
    .pressed_a  (decode_a.pressed),
    .pressed_b  (decode_b.pressed),
    .port_a     (port_a),
    .port_b     (port_b),
    .osd_button (osd_button),
    .ioctl      (ioctl),
    .dip_sw     (dip_sw)
);

`default_nettype wire

//--- verif/m92_input_tb.sv
/*
 * M92 player input testbench
 * Reads steps from the tests file, drives the DUT on the falling
 * edge and compares outputs before the next falling edge.
 */

`timescale 1ns/1ns
`default_nettype none

module m92_input_tb;

    import m92_input_pkg::*;

    localparam int CLK_HALF     = 50;
    localparam int RESET_CYCLES = 10;
    localparam int MARGIN       = 20;
    localparam int MAX_FIELDS   = 26;

    logic                           clk_sys;
    logic                           reset;
    llapi_port_t                    port_a;
    llapi_port_t                    port_b;
    usb_joys_t                      usb;
    kbd_inputs_t                    kbd;
    ioctl_wr_t                      ioctl;
    player_input_t                  p1;
    player_input_t                  p2;
    player_input_t                  p3;
    player_input_t                  p4;
    logic [PLAYERS-1:0]             start_buttons;
    logic [PLAYERS-1:0]             coin;
    logic                           pause;
    logic                           osd_button;
    dip_byte_t [DIP_BYTES_USED-1:0] dip_sw;

    string       steps[$];
    logic [31:0] fld[MAX_FIELDS];
    bit          tests_loaded = 1'b0;
    longint      watchdog_ns;

    m92_input_top m92_input_top_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .port_a        (port_a),
        .port_b        (port_b),
        .usb           (usb),
        .kbd           (kbd),
        .ioctl         (ioctl),
        .p1            (p1),
        .p2            (p2),
        .p3            (p3),
        .p4            (p4),
        .start_buttons (start_buttons),
        .coin          (coin),
        .pause         (pause),
        .osd_button    (osd_button),
        .dip_sw        (dip_sw)
    );

    initial clk_sys = 1'b0;
    always #CLK_HALF clk_sys = ~clk_sys;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic load_tests();
        int    fd;
        string line;
        fd = $fopen("verif/m92_input_tests.txt", "r");
        if (fd == 0) begin
            stop_with_error("Could not open the tests file");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            // Skip blank and comment lines
            if (line.len() > 0 && (line[0] == "V" || line[0] == "W" || line[0] == "R")) begin
                steps.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    // Hex fields after the step letter, up to a # comment
    task automatic parse_fields(input string s, output int count);
        logic [7:0]  c;
        logic [3:0]  nib;
        logic [31:0] acc;
        bit          in_tok;
        bit          is_hex;
        count  = 0;
        acc    = '0;
        in_tok = 1'b0;
        for (int i = 1; i < s.len(); i++) begin
            c = s[i];
            if (c == "#") break;
            is_hex = 1'b1;
            nib    = '0;
            if (c >= "0" && c <= "9") nib = 4'(c - "0");
            else if (c >= "a" && c <= "f") nib = 4'(c - "a" + 8'd10);
            else if (c >= "A" && c <= "F") nib = 4'(c - "A" + 8'd10);
            else is_hex = 1'b0;
            if (is_hex) begin
                acc    = {acc[27:0], nib};
                in_tok = 1'b1;
            end else if (in_tok) begin
                if (count < MAX_FIELDS) fld[count] = acc;
                count++;
                acc    = '0;
                in_tok = 1'b0;
            end
        end
        if (in_tok) begin
            if (count < MAX_FIELDS) fld[count] = acc;
            count++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_vector();
        port_a.buttons = fld[0];
        port_a.type_id = fld[1][7:0];
        port_a.en      = fld[2][0];
        port_b.buttons = fld[3];
        port_b.type_id = fld[4][7:0];
        port_b.en      = fld[5][0];
        for (int i = 0; i < PLAYERS; i++) begin
            usb.joy[i] = fld[6+i][JOY_BITS-1:0];
            kbd.p[i]   = fld[10+i][KBD_BITS-1:0];
        end
        kbd.start = fld[14][PLAYERS-1:0];
        kbd.coin  = fld[15][PLAYERS-1:0];
        kbd.pause = fld[16][0];
    endtask

    task automatic check_vector();
        check_value("p1", fld[17], 32'(p1));
        check_value("p2", fld[18], 32'(p2));
        check_value("p3", fld[19], 32'(p3));
        check_value("p4", fld[20], 32'(p4));
        check_value("start_buttons", fld[21], 32'(start_buttons));
        check_value("coin", fld[22], 32'(coin));
        check_value("pause", fld[23], 32'(pause));
        check_value("osd_button", fld[24], 32'(osd_button));
        check_value("dip_sw", fld[25], 32'(dip_sw));
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int    count;
        string line;
        reset  = 1'b1;
        port_a = '0;
        port_b = '0;
        usb    = '0;
        kbd    = '0;
        ioctl  = '0;
        load_tests();
        watchdog_ns  = longint'(steps.size() + RESET_CYCLES + MARGIN) * 2 * CLK_HALF;
        tests_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk_sys);
        reset = 1'b0;

        foreach (steps[n]) begin
            line = steps[n];
            parse_fields(line, count);
            @(negedge clk_sys);
            reset    = 1'b0;
            ioctl.wr = 1'b0;
            if (line[0] == "V") begin
                if (count != MAX_FIELDS) stop_with_error("Malformed vector line in tests file");
                drive_vector();
            end else if (line[0] == "W") begin
                if (count != 3) stop_with_error("Malformed DIP write line in tests file");
                ioctl.wr    = 1'b1;
                ioctl.index = fld[0][7:0];
                ioctl.addr  = fld[1][IOCTL_ADDR_BITS-1:0];
                ioctl.dout  = fld[2][7:0];
            end else begin
                reset = 1'b1;
            end
            // Sample shortly before the next falling edge
            @(posedge clk_sys);
            #(CLK_HALF - 10);
            if (line[0] == "V") check_vector();
        end

        $display("Everything OK");
        $finish;
    end

    // Watchdog sized from the number of steps
    initial begin
        wait (tests_loaded);
        #(watchdog_ns);
        stop_with_error("Watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

//--- src.f
hdl/m92_input_pkg.sv
hdl/llapi_port_decode.sv
hdl/player_slot_assign.sv
hdl/arcade_input_merge.sv
hdl/dip_switch_bank.sv
hdl/m92_input_top.sv
verif/m92_input_assertions.sv
verif/m92_input_tb.sv

//--- Makefile
# Verilator build and run for the M92 player-input block

VERILATOR ?= verilator
TOP       ?= m92_input_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Everything OK

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/m92_input_tests.txt
# V a_btn a_type a_en b_btn b_type b_en usb0-3 kbd0-3 kstart kcoin kpause
#   then expected p1 p2 p3 p4 start coin pause osd dip_sw ; W index addr dout ; R
V 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 ffffff
V 0 0 0 0 0 0 401 1002 804 2208 10 0 20 0 0 0 0 11 2 24 208 3 1 1 0 ffffff
V 0 0 0 0 0 0 0 0 0 0 ffff 0 0 0 8 4 1 3ff 0 0 0 8 1 1 0 ffffff
V 21 3 1 1000090 3 1 3 400 3ff 2000 0 0 0 0 0 0 0 10 201 3 0 9 1 0 0 ffffff
V 2 3 0 2000000 5 1 11 22 44 88 0 0 0 0 0 0 0 11 2 22 44 0 0 0 0 ffffff
V 8 3 1 0 5 0 11 22 44 88 0 0 0 0 0 0 0 80 11 22 44 0 0 0 0 ffffff
R
V 0 0 1 0 ff 1 100 200 0 0 0 0 0 0 0 0 0 100 200 0 0 0 0 0 0 ffffff
V 1 0 1 0 ff 1 100 200 0 0 0 0 0 0 0 0 0 10 100 200 0 0 0 0 0 ffffff
V 0 0 1 0 ff 1 100 200 0 0 0 0 0 0 0 0 0 0 100 200 0 0 0 0 0 ffffff
V 0 0 1 2 ff 1 100 200 0 0 0 0 0 0 0 0 0 0 20 100 200 0 0 0 0 ffffff
V 0 0 1 0 ff 1 100 200 0 0 0 0 0 0 0 0 0 0 0 100 200 0 0 0 0 ffffff
V 0 0 0 0 ff 1 100 200 0 0 0 0 0 0 0 0 0 100 0 200 0 0 0 0 0 ffffff
R
V 0 0 1 0 ff 1 100 200 0 0 0 0 0 0 0 0 0 100 200 0 0 0 0 0 0 ffffff
V 4000021 3 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 14 0 0 0 1 0 0 1 ffffff
V 4000020 3 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 0 0 0 1 0 0 0 ffffff
V 21 3 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10 0 0 0 1 0 0 0 ffffff
V 4000001 3 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 14 0 0 0 0 0 0 0 ffffff
V 0 3 1 4000021 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 ffffff
W fe 0 a5
V 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 ffffa5
W fe 2 3c
W fe 1 00
V 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3c00a5
W fd 0 11
W fe 8 22
W fe 5 77
V 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3c00a5
R
V 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 ffffff
